//--- files.f
+incdir+source
source/game_display_pkg.sv
source/pixel_if.sv
source/pixel_addr_gen.sv
source/picture_mem.sv
source/layer_mixer.sv
source/game_display_top.sv
dv/game_display_asserts.sv
dv/tb_game_display.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS := --binary --timing --assert -j 0
TOP := tb_game_display
FILELIST := files.f
OBJ_DIR := obj_dir
RUN_ARGS := +verilator+error+limit+100
LOG := sim.log
PASS_MSG := Everything OK

SOURCES := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_game_display.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_display_defs.svh"

module tb_game_display;
	import game_display_pkg::*;

	localparam int N_FIXED = 32; // hand picked entries
	localparam int N_RAND = 16; // lcg positions, modes rotate
	localparam int N_TAB = N_FIXED + N_RAND;
	localparam int TIMEOUT_CYCLES = 2 * (`GD_BG_DEPTH + `GD_BN_DEPTH + N_TAB + 3);

	typedef struct packed
	{
		int mode; // raw code, 3 included
		int x;
		int y;
		int tick; // blink strobe with this entry
	} entry_t;

	logic clk;
	logic arst_n;
	game_mode_t mode;
	logic [`GD_POS_W-1:0] xpos;
	logic [`GD_POS_W-1:0] ypos;
	logic blink_tick;
	logic wr_en;
	pic_sel_t wr_sel;
	logic [`GD_ADDR_W-1:0] wr_addr;
	rgb565_t wr_data;
	rgb444_t pixel;

	rgb565_t bg_shadow [`GD_BG_DEPTH]; // copy of every host write
	mask_t bn_shadow [`GD_BN_DEPTH];
	entry_t tab [N_TAB];
	rgb444_t exp_pixel [N_TAB];
	logic [31:0] rng;
	int cycle_cnt = 0;

	// play edges, over window bounds, start blink, code 3, mixed modes
	entry_t fixed_tab [N_FIXED] = '{
		'{1, 0, 0, 0}, '{1, 1, 1, 0}, '{1, 2, 2, 0}, '{1, 3, 1, 0},
		'{1, 320, 240, 0}, '{1, 639, 479, 0}, '{1, 640, 480, 0}, '{1, 641, 10, 0},
		'{1, 10, 481, 0}, '{1, 640, 1, 0}, '{2, 95, 200, 0}, '{2, 96, 200, 0},
		'{2, 545, 200, 0}, '{2, 546, 200, 0}, '{2, 300, 85, 0}, '{2, 300, 86, 0},
		'{2, 300, 365, 0}, '{2, 300, 366, 0}, '{0, 200, 150, 0}, '{0, 201, 150, 0},
		'{0, 202, 150, 0}, '{0, 203, 150, 1}, '{0, 204, 150, 0}, '{0, 205, 150, 0},
		'{0, 206, 150, 1}, '{0, 207, 150, 0}, '{0, 208, 150, 0}, '{3, 300, 200, 0},
		'{3, 10, 10, 0}, '{2, 400, 300, 0}, '{0, 400, 301, 0}, '{1, 400, 302, 0}
	};

	game_display_top u_dut
	(
		.clk(clk),
		.arst_n(arst_n),
		.mode(mode),
		.xpos(xpos),
		.ypos(ypos),
		.blink_tick(blink_tick),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.pixel(pixel)
	);

	always #4 clk = ~clk; // 8 ns period

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES)
		begin
			$display("Timeout: run still going after %0d clock cycles", TIMEOUT_CYCLES);
			stop_on_failure();
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// expected colour from the screen rules and the shadow pictures
	function automatic rgb444_t ref_pixel(input int m, input int x, input int y,
		input logic blink);
		logic hit_bg;
		logic hit_bn;
		int bg_idx;
		int bn_idx;
		rgb565_t w;
		mask_t mk;
		rgb444_t p;
		hit_bg = x > 0 && x <= `GD_SCREEN_W && y > 0 && y <= `GD_SCREEN_H;
		hit_bn = x > `GD_BN_X0 && x <= `GD_BN_X1 && y > `GD_BN_Y0 && y <= `GD_BN_Y1;
		bg_idx = x / 2 + `GD_BG_W * (y / 2); // 2x2 block per word
		w = (hit_bg && bg_idx < `GD_BG_DEPTH) ? bg_shadow[bg_idx] : 16'h0000;
		p = {w[15:12], w[10:7], w[4:1]}; // top nibble of each channel
		if (hit_bn && (m == 2 || (m == 0 && blink)))
		begin
			bn_idx = (y - `GD_BN_Y0 - 1) * `GD_BN_W + (x - `GD_BN_X0 - 1);
			mk = bn_shadow[bn_idx];
			p = p | {{4{mk[2]}}, {4{mk[1]}}, {4{mk[0]}}};
		end
		if (m == 3)
			p = 12'h000; // unused mode code
		return p;
	endfunction

	task automatic stop_on_failure();
		$display("Something failed");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_pixel(input string name, input rgb444_t got, input rgb444_t exp);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_mode_name(input string name, input game_mode_t got,
		input game_mode_t exp);
		if (got !== exp)
		begin
			$display("Error at %0t ns: %s = %s(%0d), expected %s(%0d)", $time, name,
				got.name(), got, exp.name(), exp);
			stop_on_failure();
		end
	endtask

	task automatic build_table();
		for (int i = 0; i < N_FIXED; i++)
			tab[i] = fixed_tab[i];
		for (int i = N_FIXED; i < N_TAB; i++)
		begin
			tab[i].mode = i % 4; // back to back mode changes
			rng = lcg_next(rng);
			tab[i].x = int'(rng[31:16]) % 700; // some off screen
			rng = lcg_next(rng);
			tab[i].y = int'(rng[31:16]) % 520;
			tab[i].tick = int'(rng[31]);
		end
	endtask

	// fill both rams through the host port, output must stay black
	task automatic load_pictures();
		for (int a = 0; a < `GD_BG_DEPTH + `GD_BN_DEPTH; a++)
		begin
			@(negedge clk);
			check_pixel("pixel", pixel, 12'h000);
			rng = lcg_next(rng);
			wr_en = 1'b1;
			wr_data = rng[31:16];
			if (a < `GD_BG_DEPTH)
			begin
				wr_sel = SEL_BG;
				wr_addr = `GD_ADDR_W'(a);
				bg_shadow[a] = rng[31:16];
			end
			else
			begin
				wr_sel = SEL_BN;
				wr_addr = `GD_ADDR_W'(a - `GD_BG_DEPTH);
				bn_shadow[a - `GD_BG_DEPTH] = rng[18:16]; // ram keeps low 3 bits
			end
		end
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	// a tick sampled with entry k reaches the mixer while entry k-2 leaves
	task automatic compute_expected();
		logic b;
		logic b_state [N_TAB];
		int j;
		b = 1'b1; // banner visible from reset
		for (int i = 0; i < N_TAB; i++)
		begin
			if (tab[i].tick != 0)
				b = ~b;
			b_state[i] = b;
		end
		for (int i = 0; i < N_TAB; i++)
		begin
			j = (i + 2 < N_TAB) ? i + 2 : N_TAB - 1;
			exp_pixel[i] = ref_pixel(tab[i].mode, tab[i].x, tab[i].y, b_state[j]);
		end
	endtask

	task automatic run_table();
		for (int k = 0; k < N_TAB + 3; k++)
		begin
			@(negedge clk);
			if (k >= 3)
				check_pixel("pixel", pixel, exp_pixel[k-3]); // 3 cycles in flight
			if (k >= 2 && k < N_TAB + 2)
				check_mode_name("u_dut.u_pic_if.mode", u_dut.u_pic_if.mode,
					game_mode_t'(tab[k-2].mode));
			if (k < N_TAB)
			begin
				mode = game_mode_t'(tab[k].mode);
				xpos = `GD_POS_W'(tab[k].x);
				ypos = `GD_POS_W'(tab[k].y);
				blink_tick = (tab[k].tick != 0);
			end
			else
			begin
				mode = MODE_PLAY; // drain
				xpos = '0;
				ypos = '0;
				blink_tick = 1'b0;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		arst_n = 1'b0;
		mode = MODE_OVER; // differs from the reset value of the mode registers
		xpos = '0;
		ypos = '0;
		blink_tick = 1'b0;
		wr_en = 1'b0;
		wr_sel = SEL_BG;
		wr_addr = '0;
		wr_data = '0;
		rng = 32'hfe06_5901;
		build_table();
		repeat (3)
		begin
			@(negedge clk);
			check_pixel("pixel", pixel, 12'h000); // reset values
			check_mode_name("u_dut.u_pic_if.mode", u_dut.u_pic_if.mode, MODE_PLAY);
		end
		arst_n = 1'b1;
		load_pictures();
		compute_expected();
		run_table();
		if (u_dut.u_asserts.fail_cnt == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
		begin
			$display("Bound assertions failed %0d times", u_dut.u_asserts.fail_cnt);
			stop_on_failure();
		end
	end

endmodule

`default_nettype wire

//--- dv/game_display_asserts.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_display_defs.svh"

module game_display_asserts
(
	input wire clk,
	input wire arst_n,
	input wire [1:0] mode,
	input wire [`GD_POS_W-1:0] xpos,
	input wire [`GD_POS_W-1:0] ypos,
	input wire wr_en,
	input wire [`GD_ADDR_W-1:0] wr_addr,
	input wire [11:0] pixel
);
	int fail_cnt = 0; // failed assertion count

	// black output while reset held
	reset_black: assert property (@(posedge clk) !arst_n |-> pixel == 12'h000)
	else
	begin
		fail_cnt++;
		$error("pixel not zero during reset");
	end

	// three register stages, known in gives known out
	known_latency: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({mode, xpos, ypos}) |-> ##3 !$isunknown(pixel))
	else
	begin
		fail_cnt++;
		$error("pixel unknown three cycles after a known position");
	end

	write_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
		wr_en |-> !$isunknown(wr_addr))
	else
	begin
		fail_cnt++;
		$error("host write with unknown address");
	end

endmodule

bind game_display_top game_display_asserts u_asserts
(
	.clk(clk),
	.arst_n(arst_n),
	.mode(mode),
	.xpos(xpos),
	.ypos(ypos),
	.wr_en(wr_en),
	.wr_addr(wr_addr),
	.pixel(pixel)
);

`default_nettype wire

//--- source/game_display_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_display_defs.svh"

module game_display_top
(
	input wire clk,
	input wire arst_n,
	input wire game_display_pkg::game_mode_t mode,
	input wire [`GD_POS_W-1:0] xpos, // from display timer
	input wire [`GD_POS_W-1:0] ypos,
	input wire blink_tick,
	input wire wr_en, // host picture load
	input wire game_display_pkg::pic_sel_t wr_sel,
	input wire [`GD_ADDR_W-1:0] wr_addr,
	input wire game_display_pkg::rgb565_t wr_data,
	output game_display_pkg::rgb444_t pixel // 3 cycles after position
);

	addr_if u_addr_if (); // addr gen -> memory
	pic_if u_pic_if (); // memory -> mixer

	pixel_addr_gen u_addr_gen
	(
		.clk(clk),
		.arst_n(arst_n),
		.mode(mode),
		.xpos(xpos),
		.ypos(ypos),
		.addr(u_addr_if)
	);

	picture_mem u_picture_mem
	(
		.clk(clk),
		.arst_n(arst_n),
		.wr_en(wr_en),
		.wr_sel(wr_sel),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.addr(u_addr_if),
		.pic(u_pic_if)
	);

	layer_mixer u_layer_mixer
	(
		.clk(clk),
		.arst_n(arst_n),
		.blink_tick(blink_tick),
		.pic(u_pic_if),
		.pixel(pixel)
	);

endmodule

`default_nettype wire

//--- source/layer_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module layer_mixer
(
	input wire clk,
	input wire arst_n,
	input wire blink_tick, // one cycle pulse, toggles banner
	pic_if.dst pic,
	output game_display_pkg::rgb444_t pixel
);
	import game_display_pkg::*;

	logic blink_on; // banner visible in start mode
	logic blink_next; // state seen by the pixel leaving now
	logic show_bn; // overlay enable
	rgb444_t bg_444; // converted background
	rgb444_t bn_444; // mask spread to nibbles
	rgb444_t pixel_c;

	assign blink_next = blink_on ^ blink_tick;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			blink_on <= 1'b1; // banner starts visible
		else
			blink_on <= blink_next;
	end

	// top 4 bits of r, g and b
	assign bg_444 = pic.in_bg ?
		{pic.bg_data[15:12], pic.bg_data[10:7], pic.bg_data[4:1]} : '0;

	assign bn_444 = {{4{pic.bn_data[2]}}, {4{pic.bn_data[1]}}, {4{pic.bn_data[0]}}};

	always_comb
	begin
		show_bn = 1'b0;
		pixel_c = bg_444;
		case (pic.mode)
			MODE_START:
				show_bn = pic.in_bn && blink_next; // blinking title
			MODE_PLAY:
				show_bn = 1'b0; // background only
			MODE_OVER:
				show_bn = pic.in_bn; // steady banner
			default:
				pixel_c = '0; // unused code, black
		endcase
		if (show_bn)
			pixel_c = bg_444 | bn_444; // mask lights whole nibble
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pixel <= '0;
		else
			pixel <= pixel_c;
	end

endmodule

`default_nettype wire

//--- source/picture_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_display_defs.svh"

module picture_mem
(
	input wire clk,
	input wire arst_n,
	input wire wr_en, // single cycle host strobe
	input wire game_display_pkg::pic_sel_t wr_sel,
	input wire [`GD_ADDR_W-1:0] wr_addr,
	input wire game_display_pkg::rgb565_t wr_data,
	addr_if.dst addr,
	pic_if.src pic
);
	import game_display_pkg::*;

	rgb565_t bg_ram [`GD_BG_DEPTH]; // 320x240 background
	mask_t bn_ram [`GD_BN_DEPTH]; // 450x280 banner mask
	logic bg_hit; // read address inside stored picture

	// bottom row / right column of the screen map past the last word
	assign bg_hit = addr.bg_addr < `GD_BG_DEPTH;

	// host write port
	always_ff @(posedge clk)
	begin
		if (wr_en && (wr_sel == SEL_BG))
			bg_ram[wr_addr] <= wr_data;
		if (wr_en && (wr_sel == SEL_BN))
			bn_ram[wr_addr] <= wr_data[2:0]; // low bits only
	end

	// registered read, same-cycle write gives old data
	always_ff @(posedge clk)
	begin
		pic.bg_data <= bg_hit ? bg_ram[addr.bg_addr] : '0;
		pic.bn_data <= bn_ram[addr.bn_addr];
	end

	// side band follows the read data
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pic.in_bg <= 1'b0;
			pic.in_bn <= 1'b0;
			pic.mode <= MODE_PLAY;
		end
		else
		begin
			pic.in_bg <= addr.in_bg;
			pic.in_bn <= addr.in_bn;
			pic.mode <= addr.mode;
		end
	end

endmodule

`default_nettype wire

//--- source/pixel_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_display_defs.svh"

module pixel_addr_gen
(
	input wire clk,
	input wire arst_n,
	input wire game_display_pkg::game_mode_t mode,
	input wire [`GD_POS_W-1:0] xpos,
	input wire [`GD_POS_W-1:0] ypos,
	addr_if.src addr
);
	import game_display_pkg::*;

	logic in_bg_c; // visible screen hit
	logic in_bn_c; // banner window hit
	logic [`GD_ADDR_W-1:0] x_half; // background column
	logic [`GD_ADDR_W-1:0] y_half; // background row
	logic [`GD_ADDR_W-1:0] bn_col; // column inside banner, 0 based
	logic [`GD_ADDR_W-1:0] bn_row; // row inside banner, 0 based
	logic [`GD_ADDR_W-1:0] bg_addr_c;
	logic [`GD_ADDR_W-1:0] bn_addr_c;

	assign in_bg_c = (xpos > 0) && (xpos <= `GD_SCREEN_W) &&
		(ypos > 0) && (ypos <= `GD_SCREEN_H);
	assign in_bn_c = (xpos > `GD_BN_X0) && (xpos <= `GD_BN_X1) &&
		(ypos > `GD_BN_Y0) && (ypos <= `GD_BN_Y1);

	// each stored pixel covers a 2x2 screen block
	assign x_half = `GD_ADDR_W'(xpos[`GD_POS_W-1:1]);
	assign y_half = `GD_ADDR_W'(ypos[`GD_POS_W-1:1]);
	assign bg_addr_c = `GD_ADDR_W'(x_half + y_half * `GD_BG_W);

	// first pixel inside the window is X0+1 / Y0+1, mapped to word 0
	assign bn_col = `GD_ADDR_W'(xpos) - `GD_ADDR_W'(`GD_BN_X0 + 1);
	assign bn_row = `GD_ADDR_W'(ypos) - `GD_ADDR_W'(`GD_BN_Y0 + 1);
	assign bn_addr_c = `GD_ADDR_W'(bn_row * `GD_BN_W + bn_col);

	// flags and mode
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			addr.in_bg <= 1'b0;
			addr.in_bn <= 1'b0;
			addr.mode <= MODE_PLAY;
		end
		else
		begin
			addr.in_bg <= in_bg_c;
			addr.in_bn <= in_bn_c;
			addr.mode <= mode;
		end
	end

	// addresses held at zero off window
	always_ff @(posedge clk)
	begin
		addr.bg_addr <= in_bg_c ? bg_addr_c : '0;
		addr.bn_addr <= in_bn_c ? bn_addr_c : '0;
	end

endmodule

`default_nettype wire

//--- source/pixel_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "game_display_defs.svh"

// address stage -> memory stage
interface addr_if;
	import game_display_pkg::*;

	logic [`GD_ADDR_W-1:0] bg_addr; // background word address
	logic [`GD_ADDR_W-1:0] bn_addr; // banner word address
	logic in_bg; // position on visible screen
	logic in_bn; // position inside banner window
	game_mode_t mode; // mode sampled with the position

	modport src (output bg_addr, output bn_addr, output in_bg, output in_bn, output mode);
	modport dst (input bg_addr, input bn_addr, input in_bg, input in_bn, input mode);
endinterface

// memory stage -> mixer
interface pic_if;
	import game_display_pkg::*;

	rgb565_t bg_data; // background word, registered read
	mask_t bn_data; // banner mask, registered read
	logic in_bg; // flags delayed to match the read
	logic in_bn;
	game_mode_t mode;

	modport src (output bg_data, output bn_data, output in_bg, output in_bn, output mode);
	modport dst (input bg_data, input bn_data, input in_bg, input in_bn, input mode);
endinterface

`default_nettype wire

//--- source/game_display_pkg.sv
`default_nettype none

package game_display_pkg;

	// screen mode, same coding as the game FSM
	typedef enum logic [1:0]
	{
		MODE_START = 2'd0, // title, blinking banner
		MODE_PLAY  = 2'd1, // background only
		MODE_OVER  = 2'd2  // steady banner
	} game_mode_t; // code 3 is left unnamed, shows black

	// host write target
	typedef enum logic
	{
		SEL_BG = 1'b0, // background ram
		SEL_BN = 1'b1  // banner ram
	} pic_sel_t;

	typedef logic [15:0] rgb565_t; // r[15:11] g[10:5] b[4:0]
	typedef logic [11:0] rgb444_t; // r[11:8] g[7:4] b[3:0]
	typedef logic [2:0] mask_t; // bit2 red, bit1 green, bit0 blue

endpackage

`default_nettype wire

//--- source/game_display_defs.svh
`ifndef GAME_DISPLAY_DEFS_SVH
`define GAME_DISPLAY_DEFS_SVH

// visible screen, background shown at 1..640 x 1..480
`define GD_SCREEN_W 640
`define GD_SCREEN_H 480

// stored background, one word per 2x2 screen block
`define GD_BG_W 320
`define GD_BG_H 240
`define GD_BG_DEPTH (`GD_BG_W * `GD_BG_H)

// banner window, inside when lower < pos <= upper
`define GD_BN_X0 95
`define GD_BN_X1 545
`define GD_BN_Y0 85
`define GD_BN_Y1 365

`define GD_BN_W (`GD_BN_X1 - `GD_BN_X0)
`define GD_BN_DEPTH (`GD_BN_W * (`GD_BN_Y1 - `GD_BN_Y0))

// datapath widths
`define GD_POS_W 11
`define GD_ADDR_W 17

`endif
